/* flist.f */
rtl/exu_pkg.sv
rtl/stage_reg.sv
rtl/exec_unit.sv
rtl/data_mem.sv
rtl/wb_stage.sv
rtl/exec_pipe.sv
sim/tb_exec_pipe.sv

/* Makefile */
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_exec_pipe
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_exec_pipe.sv */
`default_nettype none

module tb_exec_pipe import exu_pkg::*; ();

    localparam int CYCLE_LIMIT = 2000;

    typedef struct packed {
        pc_t   pc;
        lreg_t rd;
        logic  we;
        xlen_t data;
    } expect_t;

    logic   clock;
    logic   reset_n;
    logic   issue_valid;
    logic   issue_ready;
    issue_t issue_data;
    logic   retire_valid;
    logic   retire_ready = 1'b1;
    lreg_t  retire_rd;
    xlen_t  retire_data;
    pc_t    retire_pc;
    logic   retire_we;
    logic   redirect_valid;
    pc_t    redirect_pc;

    expect_t    exp_q[$];                          // program order, pushed at accept
    expect_t    head;
    logic [7:0] shadow [1024] = '{default: 8'h00}; // byte image of data_mem
    pc_t        next_pc;
    integer     seed = 85348;
    logic       random_ready;
    int         cycles = 0;
    int         rd_ptr = 0;
    int         test_errors = 0;
    int         check_errors = 0;
    int         last_accept = 0;
    int         last_retire = 0;

    exec_pipe #(.MEM_WORDS(256)) u_dut (
        .clock          (clock),
        .reset_n        (reset_n),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_data     (issue_data),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_pc      (retire_pc),
        .retire_we      (retire_we),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d instructions not retired",
                     cycles, exp_q.size() - rd_ptr);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(posedge clock) begin
        if (random_ready) begin
            retire_ready <= ($random(seed) & 3) != 0;   // ready about 3 cycles in 4
        end else begin
            retire_ready <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic bit report_mismatch(input string name, input xlen_t got,
                                           input xlen_t want);
        if (got !== want) begin
            $display("error at %0t: %s expected %h got %h", $time, name, want, got);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic xlen_t model_alu(input alu_op_e f, input xlen_t a, input xlen_t b);
        xlen_t fill;
        fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0;   // sign bits shifted in
        case (f)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return (a >> b[4:0]) | fill;
            SLT:     return {31'h0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            SLTU:    return {31'h0, a < b};
            default: return b;                                // lui
        endcase
    endfunction

    function automatic logic branch_taken(input cx_type_e kind, input xlen_t a,
                                          input xlen_t b, input logic uns);
        xlen_t flip;
        logic  less;
        flip = uns ? 32'h0 : 32'h8000_0000;
        less = (a ^ flip) < (b ^ flip);
        case (kind)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return less;
            BGE:       return !less;
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic xlen_t model_load(input xlen_t addr, input ls_size_e size,
                                         input logic uns);
        logic [9:0]  a;
        logic [15:0] half;
        a    = addr[9:0];
        half = {shadow[a + 10'd1], shadow[a]};
        case (size)
            BYTE:    return uns ? {24'h0, shadow[a]} : {{24{shadow[a][7]}}, shadow[a]};
            HALF:    return uns ? {16'h0, half} : {{16{half[15]}}, half};
            default: return {shadow[a + 10'd3], shadow[a + 10'd2], half};
        endcase
    endfunction

    task automatic model_store(input xlen_t addr, input ls_size_e size, input xlen_t data);
        logic [9:0] a;
        a = addr[9:0];
        shadow[a] = data[7:0];
        if (size != BYTE) begin
            shadow[a + 10'd1] = data[15:8];
        end
        if (size == WORD) begin
            shadow[a + 10'd2] = data[23:16];
            shadow[a + 10'd3] = data[31:24];
        end
    endtask

    task automatic push_expect(input issue_t op);
        expect_t e;
        e.pc   = op.pc;
        e.rd   = op.rd;
        e.we   = op.need_to_wb && (op.rd != 5'd0);
        e.data = '0;
        if (op.is_store) begin
            model_store(op.src1 + op.imm, op.ls_size, op.src2);
        end else if (op.is_load) begin
            e.data = model_load(op.src1 + op.imm, op.ls_size, op.is_unsigned);
        end else if (op.cx_type == JAL || op.cx_type == JALR) begin
            e.data = op.pc + 32'd4;                               // link
        end else begin
            e.data = model_alu(op.alu_op, op.src1, op.src2_is_imm ? op.imm : op.src2);
        end
        exp_q.push_back(e);
    endtask

    // ------------------------------------------------------------
    // retire checker
    // ------------------------------------------------------------
    always @(posedge clock) begin
        if (reset_n && retire_valid && retire_ready) begin
            if (rd_ptr >= exp_q.size()) begin
                $display("retire of pc %h at %0t with no instruction outstanding",
                         retire_pc, $time);
                check_errors++;
            end else begin
                head = exp_q[rd_ptr];
                if (report_mismatch("retire_pc", retire_pc, head.pc)) check_errors++;
                if (report_mismatch("retire_rd", xlen_t'(retire_rd), xlen_t'(head.rd))) begin
                    check_errors++;
                end
                if (report_mismatch("retire_we", xlen_t'(retire_we), xlen_t'(head.we))) begin
                    check_errors++;
                end
                if (head.we && report_mismatch("retire_data", retire_data, head.data)) begin
                    check_errors++;
                end
                rd_ptr++;
                last_retire = cycles;
            end
        end
    end

    // ------------------------------------------------------------
    // issue driver
    // ------------------------------------------------------------
    function automatic issue_t alu_inst(input alu_op_e f, input lreg_t rd, input xlen_t a,
                                        input xlen_t b, input logic use_imm);
        issue_t op;
        op             = '0;
        op.alu_op      = f;
        op.rd          = rd;
        op.src1        = a;
        op.need_to_wb  = 1'b1;
        op.src2_is_imm = use_imm;
        if (use_imm) begin
            op.imm = b;
        end else begin
            op.src2 = b;
        end
        return op;
    endfunction

    function automatic issue_t mem_inst(input logic store, input ls_size_e size,
                                        input logic uns, input lreg_t rd, input xlen_t base,
                                        input xlen_t off, input xlen_t data);
        issue_t op;
        op             = '0;
        op.is_store    = store;
        op.is_load     = !store;
        op.need_to_wb  = !store;
        op.ls_size     = size;
        op.is_unsigned = uns;
        op.rd          = store ? 5'd0 : rd;
        op.src1        = base;
        op.imm         = off;
        op.src2        = data;
        return op;
    endfunction

    task automatic issue_op(input issue_t op);
        op.pc   = next_pc;
        next_pc = next_pc + 32'd4;
        issue_valid <= 1'b1;
        issue_data  <= op;
        do @(posedge clock); while (!issue_ready);
        last_accept = cycles;
        push_expect(op);
    endtask

    task automatic drain();
        issue_valid <= 1'b0;
        while (rd_ptr != exp_q.size()) @(posedge clock);
        repeat (3) @(posedge clock);                     // room for a stray retire
    endtask

    // branch followed by one instruction that must die when the branch is taken
    task automatic run_branch(input cx_type_e kind, input xlen_t a, input xlen_t b,
                              input logic uns, input xlen_t off);
        issue_t br;
        issue_t nxt;
        logic   taken;
        pc_t    target;
        br            = '0;
        br.cx_type    = kind;
        br.src1       = a;
        br.src2       = b;
        br.imm        = off;
        br.is_unsigned = uns;
        br.rd         = 5'd1;
        br.need_to_wb = (kind == JAL) || (kind == JALR);
        taken  = branch_taken(kind, a, b, uns);
        target = (kind == JALR) ? ((a + off) & ~32'd1) : (next_pc + off);
        issue_op(br);
        nxt     = alu_inst(ADD, 5'd9, next_pc, 32'd1, 1'b1);
        nxt.pc  = next_pc;
        next_pc = next_pc + 32'd4;
        issue_valid <= 1'b1;
        issue_data  <= nxt;
        @(posedge clock);
        if (report_mismatch("redirect_valid", xlen_t'(redirect_valid), xlen_t'(taken))) begin
            test_errors++;
        end
        if (taken && report_mismatch("redirect_pc", redirect_pc, target)) test_errors++;
        while (!issue_ready) @(posedge clock);
        if (!taken) begin
            push_expect(nxt);
        end
        issue_valid <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_timing();
        if (report_mismatch("retire_valid", xlen_t'(retire_valid), 32'd0)) test_errors++;
        if (report_mismatch("issue_ready", xlen_t'(issue_ready), 32'd1)) test_errors++;
        issue_op(alu_inst(ADD, 5'd3, 32'd20, 32'd22, 1'b0));
        drain();
        if (report_mismatch("retire latency", xlen_t'(last_retire - last_accept), 32'd3)) begin
            test_errors++;
        end
    endtask

    task automatic test_alu();
        alu_op_e ops [11];
        xlen_t   a;
        xlen_t   b;
        ops = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B};
        for (int k = 0; k < 11; k++) begin
            a = xlen_t'(k + 1) * 32'h9e37_79b9;
            b = a ^ 32'h5bd1_e995;
            issue_op(alu_inst(ops[k], 5'(k + 1), a, b, 1'b0));
            issue_op(alu_inst(ops[k], 5'(k + 12), b, a >> 20, 1'b1));
        end
        issue_op(alu_inst(SLT, 5'd24, 32'hffff_ffff, 32'd1, 1'b0));
        issue_op(alu_inst(SLTU, 5'd25, 32'hffff_ffff, 32'd1, 1'b0));
        issue_op(alu_inst(SRA, 5'd26, 32'h8000_0f00, 32'd7, 1'b1));
        issue_op(alu_inst(PASS_B, 5'd27, 32'h0, 32'h1234_5000, 1'b1));
        issue_op(alu_inst(ADD, 5'd0, 32'd5, 32'd6, 1'b0));     // x0, no write
        drain();
    endtask

    task automatic test_mem();
        issue_op(mem_inst(1'b1, WORD, 1'b0, 5'd0, 32'h40, 32'h0, 32'h89ab_cdef));
        issue_op(mem_inst(1'b1, WORD, 1'b0, 5'd0, 32'h40, 32'h4, 32'h1234_5678));
        issue_op(mem_inst(1'b1, HALF, 1'b0, 5'd0, 32'h40, 32'h6, 32'hffff_8001));
        issue_op(mem_inst(1'b1, BYTE, 1'b0, 5'd0, 32'h40, 32'h5, 32'h0000_00a5));
        issue_op(mem_inst(1'b1, BYTE, 1'b0, 5'd0, 32'h48, 32'h3, 32'h0000_0080));
        for (int k = 0; k < 12; k++) begin
            issue_op(mem_inst(1'b0, BYTE, 1'b0, 5'(k + 1), 32'h40, xlen_t'(k), 0));
            issue_op(mem_inst(1'b0, BYTE, 1'b1, 5'(k + 2), 32'h40, xlen_t'(k), 0));
            if (k % 2 == 0) begin
                issue_op(mem_inst(1'b0, HALF, 1'b0, 5'(k + 3), 32'h40, xlen_t'(k), 0));
                issue_op(mem_inst(1'b0, HALF, 1'b1, 5'(k + 4), 32'h40, xlen_t'(k), 0));
            end
            if (k % 4 == 0) begin
                issue_op(mem_inst(1'b0, WORD, 1'b0, 5'(k + 5), 32'h40, xlen_t'(k), 0));
            end
        end
        drain();
    endtask

    task automatic test_branch();
        run_branch(BEQ, 32'd5, 32'd5, 1'b0, 32'd16);
        run_branch(BEQ, 32'd5, 32'd6, 1'b0, 32'd16);
        run_branch(BNE, 32'd5, 32'd6, 1'b0, 32'd24);
        run_branch(BNE, 32'd7, 32'd7, 1'b0, 32'd24);
        run_branch(BLT, 32'hffff_ffff, 32'd1, 1'b0, 32'hffff_fff0);
        run_branch(BLT, 32'hffff_ffff, 32'd1, 1'b1, 32'hffff_fff0);   // unsigned
        run_branch(BLT, 32'd2, 32'd2, 1'b0, 32'd8);
        run_branch(BGE, 32'd3, 32'hffff_fffe, 1'b0, 32'd12);
        run_branch(BGE, 32'd3, 32'hffff_fffe, 1'b1, 32'd12);
        run_branch(BGE, 32'd2, 32'd2, 1'b0, 32'd8);
        run_branch(JAL, 32'd0, 32'd0, 1'b0, 32'hffff_fff8);
        run_branch(JALR, 32'h0000_1001, 32'd0, 1'b0, 32'd4);         // bit 0 cleared
        drain();
    endtask

    task automatic test_backpressure();
        xlen_t value;
        xlen_t addr;
        for (int k = 0; k < 24; k++) begin
            value = xlen_t'(k + 3) * 32'h85eb_ca6b;
            addr  = 32'h100 + xlen_t'(k * 4);
            case (k % 4)
                0: issue_op(alu_inst(ADD, 5'(k + 1), value, 32'd7, 1'b0));
                1: begin
                    issue_op(mem_inst(1'b1, WORD, 1'b0, 5'd0, addr, 32'h0, value));
                    issue_op(mem_inst(1'b1, BYTE, 1'b0, 5'd0, addr, 32'h2, ~value));
                    issue_op(mem_inst(1'b0, WORD, 1'b0, 5'(k + 1), addr, 32'h0, 0));
                end
                2: run_branch(BNE, value, {value[31:1], 1'b0}, 1'b0, 32'd32);
                default: issue_op(alu_inst(XOR, 5'(k + 1), value, 32'h5a5, 1'b1));
            endcase
        end
        drain();
    endtask

    initial begin
        reset_n      = 1'b0;
        issue_valid  = 1'b0;
        issue_data   = '0;
        random_ready = 1'b0;
        next_pc      = 32'h0000_1000;
        repeat (8) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        test_timing();
        random_ready <= 1'b1;
        test_alu();
        test_mem();
        test_branch();
        test_backpressure();
        $display("errors: %0d in tests, %0d at retire, %0d instructions retired",
                 test_errors, check_errors, rd_ptr);
        if (test_errors + check_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/exec_pipe.sv */
`default_nettype none

module exec_pipe import exu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic   clock,
    input  logic   reset_n,
    // issue port
    input  logic   issue_valid,
    output logic   issue_ready,
    input  issue_t issue_data,
    // retire port
    output logic   retire_valid,
    input  logic   retire_ready,
    output lreg_t  retire_rd,
    output xlen_t  retire_data,
    output pc_t    retire_pc,
    output logic   retire_we,
    // to the front end
    output logic   redirect_valid,
    output pc_t    redirect_pc
);

    logic    stall;
    logic    id_ex_valid;
    issue_t  id_ex_q;
    ex_mem_t ex_result;
    logic    ex_mem_valid;
    ex_mem_t ex_mem_q;
    logic    mem_we;
    xlen_t   mem_rdata;
    mem_wb_t mem_result;
    logic    mem_wb_valid;
    mem_wb_t mem_wb_q;

    assign issue_ready = !stall;

    // ------------------------------------------------------------
    // execute
    // ------------------------------------------------------------
    stage_reg #(.payload_t(issue_t)) u_id_ex (
        .clock     (clock),
        .reset_n   (reset_n),
        .stall     (stall),
        .flush     (redirect_valid),     // drop the wrong-path instruction
        .in_valid  (issue_valid),
        .in_data   (issue_data),
        .out_valid (id_ex_valid),
        .out_data  (id_ex_q)
    );

    exec_unit u_exec_unit (
        .valid          (id_ex_valid),
        .op             (id_ex_q),
        .result         (ex_result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // ------------------------------------------------------------
    // memory
    // ------------------------------------------------------------
    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clock     (clock),
        .reset_n   (reset_n),
        .stall     (stall),
        .flush     (1'b0),
        .in_valid  (id_ex_valid),
        .in_data   (ex_result),
        .out_valid (ex_mem_valid),
        .out_data  (ex_mem_q)
    );

    assign mem_we = ex_mem_valid && ex_mem_q.is_store && !stall;   // only on the leaving edge

    data_mem #(.MEM_WORDS(MEM_WORDS)) u_data_mem (
        .clock (clock),
        .we    (mem_we),
        .addr  (ex_mem_q.ls_address),
        .wdata (ex_mem_q.store_data),
        .size  (ex_mem_q.ls_size),
        .rdata (mem_rdata)
    );

    assign mem_result.pc          = ex_mem_q.pc;
    assign mem_result.instr       = ex_mem_q.instr;
    assign mem_result.rd          = ex_mem_q.rd;
    assign mem_result.need_to_wb  = ex_mem_q.need_to_wb;
    assign mem_result.is_load     = ex_mem_q.is_load;
    assign mem_result.ls_size     = ex_mem_q.ls_size;
    assign mem_result.is_unsigned = ex_mem_q.is_unsigned;
    assign mem_result.alu_result  = ex_mem_q.alu_result;
    assign mem_result.ls_address  = ex_mem_q.ls_address;
    assign mem_result.read_word   = mem_rdata;

    // ------------------------------------------------------------
    // writeback
    // ------------------------------------------------------------
    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clock     (clock),
        .reset_n   (reset_n),
        .stall     (stall),
        .flush     (1'b0),
        .in_valid  (ex_mem_valid),
        .in_data   (mem_result),
        .out_valid (mem_wb_valid),
        .out_data  (mem_wb_q)
    );

    wb_stage u_wb_stage (
        .valid        (mem_wb_valid),
        .op           (mem_wb_q),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_pc    (retire_pc),
        .stall        (stall)
    );

endmodule

`default_nettype wire

/* rtl/wb_stage.sv */
`default_nettype none

module wb_stage import exu_pkg::*; (
    input  logic    valid,
    input  mem_wb_t op,
    input  logic    retire_ready,
    output logic    retire_valid,
    output logic    retire_we,
    output lreg_t   retire_rd,
    output xlen_t   retire_data,
    output pc_t     retire_pc,
    output logic    stall
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    xlen_t       load_value;

    // ------------------------------------------------------------
    // load lane select and extension
    // ------------------------------------------------------------
    assign load_byte = op.read_word[{op.ls_address[1:0], 3'b000} +: 8];
    assign load_half = op.read_word[{op.ls_address[1], 4'b0000} +: 16];

    always_comb begin
        case (op.ls_size)
            BYTE: begin
                if (op.is_unsigned) begin
                    load_value = {24'b0, load_byte};
                end else begin
                    load_value = {{24{load_byte[7]}}, load_byte};
                end
            end
            HALF: begin
                if (op.is_unsigned) begin
                    load_value = {16'b0, load_half};
                end else begin
                    load_value = {{16{load_half[15]}}, load_half};
                end
            end
            default: load_value = op.read_word;
        endcase
    end

    // ------------------------------------------------------------
    // retire port
    // ------------------------------------------------------------
    assign retire_valid = valid;
    assign retire_rd    = op.rd;
    assign retire_pc    = op.pc;
    assign retire_data  = op.is_load ? load_value : op.alu_result;
    assign retire_we    = op.need_to_wb && (op.rd != 5'd0);   // x0 never written

    // back-pressure freezes the whole pipe
    assign stall = valid && !retire_ready;

endmodule

`default_nettype wire

/* rtl/data_mem.sv */
`default_nettype none

module data_mem import exu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic     clock,
    input  logic     we,
    input  xlen_t    addr,
    input  xlen_t    wdata,
    input  ls_size_e size,
    output xlen_t    rdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    xlen_t            mem [MEM_WORDS] = '{default: '0};
    logic [IDX_W-1:0] word_idx;
    logic [3:0]       lane_en;                // byte enables
    xlen_t            lane_data;

    assign word_idx = addr[IDX_W+1:2];

    // ------------------------------------------------------------
    // move store data onto the addressed lanes
    // ------------------------------------------------------------
    always_comb begin
        case (size)
            BYTE: begin
                lane_en   = 4'b0001 << addr[1:0];
                lane_data = wdata << {addr[1:0], 3'b000};
            end
            HALF: begin
                lane_en   = 4'b0011 << {addr[1], 1'b0};
                lane_data = wdata << {addr[1], 4'b0000};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = wdata;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) begin
                    mem[word_idx][i*8 +: 8] <= lane_data[i*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[word_idx];             // whole word, wb picks the lane

    // ------------------------------------------------------------
    // alignment
    // ------------------------------------------------------------
    assert property (@(posedge clock) (we && size == HALF) |-> (addr[0] == 1'b0))
        else $error("half store not 2-aligned at %h", addr);

    assert property (@(posedge clock) (we && size == WORD) |-> (addr[1:0] == 2'b00))
        else $error("word store not 4-aligned at %h", addr);

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`default_nettype none

module exec_unit import exu_pkg::*; (
    input  logic    valid,
    input  issue_t  op,
    output ex_mem_t result,
    output logic    redirect_valid,
    output pc_t     redirect_pc
);

    xlen_t operand_b;
    xlen_t alu_out;
    xlen_t addr_sum;
    logic  is_equal;
    logic  is_less;
    logic  is_jump;
    logic  xfer_taken;

    assign operand_b = op.src2_is_imm ? op.imm : op.src2;
    assign addr_sum  = op.src1 + op.imm;       // load/store address and jalr base

    // ------------------------------------------------------------
    // alu
    // ------------------------------------------------------------
    always_comb begin
        case (op.alu_op)
            ADD:     alu_out = op.src1 + operand_b;
            SUB:     alu_out = op.src1 - operand_b;
            AND:     alu_out = op.src1 & operand_b;
            OR:      alu_out = op.src1 | operand_b;
            XOR:     alu_out = op.src1 ^ operand_b;
            SLL:     alu_out = op.src1 << operand_b[4:0];
            SRL:     alu_out = op.src1 >> operand_b[4:0];
            SRA:     alu_out = xlen_t'($signed(op.src1) >>> operand_b[4:0]);
            SLT:     alu_out = {31'b0, $signed(op.src1) < $signed(operand_b)};
            SLTU:    alu_out = {31'b0, op.src1 < operand_b};
            PASS_B:  alu_out = operand_b;
            default: alu_out = '0;
        endcase
    end

    // ------------------------------------------------------------
    // branch and jump resolution
    // ------------------------------------------------------------
    assign is_equal = (op.src1 == op.src2);
    assign is_less  = op.is_unsigned ? (op.src1 < op.src2)
                                     : ($signed(op.src1) < $signed(op.src2));
    assign is_jump  = (op.cx_type == JAL) || (op.cx_type == JALR);

    always_comb begin
        case (op.cx_type)
            BEQ:     xfer_taken = is_equal;
            BNE:     xfer_taken = !is_equal;
            BLT:     xfer_taken = is_less;
            BGE:     xfer_taken = !is_less;
            JAL,
            JALR:    xfer_taken = 1'b1;
            default: xfer_taken = 1'b0;
        endcase
    end

    assign redirect_valid = valid && xfer_taken;
    assign redirect_pc    = (op.cx_type == JALR) ? pc_t'(addr_sum & ~32'd1)
                                                 : pc_t'(op.pc + op.imm);

    // ------------------------------------------------------------
    // payload for the memory stage
    // ------------------------------------------------------------
    always_comb begin
        result.pc          = op.pc;
        result.instr       = op.instr;
        result.rd          = op.rd;
        result.need_to_wb  = op.need_to_wb;
        result.is_load     = op.is_load;
        result.is_store    = op.is_store;
        result.ls_size     = op.ls_size;
        result.is_unsigned = op.is_unsigned;
        result.alu_result  = is_jump ? xlen_t'(op.pc + 32'd4) : alu_out; // link value
        result.ls_address  = addr_sum;
        result.store_data  = op.src2;
    end

endmodule

`default_nettype wire

/* rtl/stage_reg.sv */
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // ------------------------------------------------------------
    // stall wins over flush, the stage is frozen as a whole
    // ------------------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (flush && !stall) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (!stall) begin
            out_valid <= in_valid;
            out_data  <= in_data;
        end
    end

    // a held stage must keep its instruction across the stall edge
    assert property (@(posedge clock) disable iff (!reset_n)
        stall |=> $stable(out_valid))
        else $error("stage valid changed during stall");

endmodule

`default_nettype wire

/* rtl/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    typedef logic [31:0] xlen_t;   // operand, result and address word
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  lreg_t;   // logical register index

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        PASS_B                     // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE,
        BEQ,
        BNE,
        BLT,
        BGE,
        JAL,
        JALR
    } cx_type_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } ls_size_e;

    // ------------------------------------------------------------
    // stage payloads, valid travels beside them
    // ------------------------------------------------------------
    typedef struct packed {
        pc_t      pc;
        instr_t   instr;
        lreg_t    rs1;
        lreg_t    rs2;
        lreg_t    rd;
        xlen_t    src1;
        xlen_t    src2;
        xlen_t    imm;
        logic     src2_is_imm;
        logic     need_to_wb;
        alu_op_e  alu_op;
        cx_type_e cx_type;
        logic     is_unsigned;     // unsigned compare or zero-extended load
        logic     is_load;
        logic     is_store;
        ls_size_e ls_size;
    } issue_t;

    typedef struct packed {
        pc_t      pc;
        instr_t   instr;
        lreg_t    rd;
        logic     need_to_wb;
        logic     is_load;
        logic     is_store;
        ls_size_e ls_size;
        logic     is_unsigned;
        xlen_t    alu_result;
        xlen_t    ls_address;
        xlen_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        pc_t      pc;
        instr_t   instr;
        lreg_t    rd;
        logic     need_to_wb;
        logic     is_load;
        ls_size_e ls_size;
        logic     is_unsigned;
        xlen_t    alu_result;
        xlen_t    ls_address;
        xlen_t    read_word;       // whole memory word, lane picked in wb
    } mem_wb_t;

endpackage

`default_nettype wire
